/* verilog/csr_pkg.sv */
package csr_pkg;

    // Decoded CSR command from the pipeline.
    // Anything other than none is treated as a one-cycle request.
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_WRITE = 3'd1,
        CMD_SET   = 3'd2,
        CMD_CLEAR = 3'd3,
        CMD_ECALL = 3'd4
    } csr_cmd_e;

    // Registered request handed from decode to the register file.
    // The address is already reduced modulo the storage depth.
    typedef struct packed {
        csr_cmd_e    cmd;
        logic [11:0] addr;
        logic [31:0] operand;
    } csr_req_t;

    // Write port event, one cycle wide.
    // The same event commits to storage and updates the trap vector copy.
    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_wr_t;

    // Machine cause register, always addressed by an ecall.
    localparam logic [11:0] MCAUSE_ADDR = 12'h342;

    // Cause code for an environment call from machine mode.
    localparam logic [31:0] ECALL_CAUSE = 32'd11;

endpackage

/* verilog/csr_req_decode.sv */
module csr_req_decode #(
    parameter int CSR_ADDR_BITS = 12
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               branch_flush,
    input  csr_pkg::csr_cmd_e  csr_cmd,
    input  logic [31:0]        op1_data,
    input  logic [31:0]        imm_i,
    output csr_pkg::csr_req_t  req
);

    csr_pkg::csr_cmd_e cmd_eff;
    logic [31:0]       addr_src;
    logic [11:0]       addr_mod;

    csr_pkg::csr_cmd_e cmd_q;
    logic [11:0]       addr_q;
    logic [31:0]       operand_q;

    // A flush from writeback turns the command into a no-op.
    always_comb begin
        if (branch_flush) begin
            cmd_eff = csr_pkg::CMD_NONE;
        end else begin
            cmd_eff = csr_cmd;
        end
    end

    // An ecall reads and writes mcause, whatever the immediate holds.
    always_comb begin
        if (cmd_eff == csr_pkg::CMD_ECALL) begin
            addr_src = {20'd0, csr_pkg::MCAUSE_ADDR};
        end else begin
            addr_src = imm_i;
        end
    end

    // Keep only the index bits, so the address wraps at the storage depth.
    always_comb begin
        addr_mod = 12'(addr_src[CSR_ADDR_BITS-1:0]);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_q <= csr_pkg::CMD_NONE;
        end else begin
            cmd_q <= cmd_eff;
        end
    end

    always_ff @(posedge clk) begin
        addr_q    <= addr_mod;
        operand_q <= op1_data;
    end

    always_comb begin
        req = '{cmd: cmd_q, addr: addr_q, operand: operand_q};
    end

endmodule

/* verilog/csr_file.sv */
module csr_file #(
    parameter int CSR_ADDR_BITS = 12
) (
    input  logic              clk,
    input  logic              arst_n,
    input  csr_pkg::csr_req_t req,
    output logic [31:0]       rd_data,
    output csr_pkg::csr_wr_t  wr
);

    localparam int DEPTH = 2 ** CSR_ADDR_BITS;

    logic [31:0]       mem [DEPTH];

    logic [31:0]       rd_stored;
    logic [31:0]       rd_next;
    logic [31:0]       rd_q;

    csr_pkg::csr_cmd_e wr_cmd_q;
    logic [11:0]       wr_addr_q;
    logic [31:0]       wr_operand_q;

    // New register value from the old one and the operand.
    function automatic logic [31:0] new_value(
        input csr_pkg::csr_cmd_e cmd,
        input logic [31:0]       old,
        input logic [31:0]       operand
    );
        logic [31:0] result;
        case (cmd)
            csr_pkg::CMD_WRITE: result = operand;
            csr_pkg::CMD_SET:   result = old | operand;
            csr_pkg::CMD_CLEAR: result = old & ~operand;
            csr_pkg::CMD_ECALL: result = csr_pkg::ECALL_CAUSE;
            default:            result = '0;
        endcase
        return result;
    endfunction

    always_comb begin
        rd_stored = mem[req.addr[CSR_ADDR_BITS-1:0]];
    end

    // Read stage.
    // The write committing this cycle is newer than storage, so it wins.
    always_comb begin
        if (req.cmd == csr_pkg::CMD_NONE) begin
            rd_next = '0;
        end else if (wr.en && (wr.addr == req.addr)) begin
            rd_next = wr.data;
        end else begin
            rd_next = rd_stored;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_q     <= '0;
            wr_cmd_q <= csr_pkg::CMD_NONE;
        end else begin
            rd_q     <= rd_next;
            wr_cmd_q <= req.cmd;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_q    <= req.addr;
        wr_operand_q <= req.operand;
    end

    // Write stage works on the old value held in the read register.
    always_comb begin
        wr = '{
            en:   (wr_cmd_q != csr_pkg::CMD_NONE),
            addr: wr_addr_q,
            data: new_value(wr_cmd_q, rd_q, wr_operand_q)
        };
    end

    // Storage has no reset.
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr[CSR_ADDR_BITS-1:0]] <= wr.data;
        end
    end

    always_comb begin
        rd_data = rd_q;
    end

endmodule

/* verilog/csr_result_out.sv */
module csr_result_out #(
    parameter logic [11:0] TVEC_ADDR = 12'h305
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [31:0]      rd_data,
    input  csr_pkg::csr_wr_t wr,
    output logic [31:0]      csr_rdata,
    output logic [31:0]      trap_vector
);

    logic        tv_hit;
    logic        tv_hit_q;
    logic [31:0] tv_data_q;

    // A write to mtvec seen on the write port.
    always_comb begin
        tv_hit = wr.en && (wr.addr == TVEC_ADDR);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_rdata   <= '0;
            tv_hit_q    <= 1'b0;
            trap_vector <= '0;
        end else begin
            csr_rdata <= rd_data;
            tv_hit_q  <= tv_hit;
            // Copy follows storage one cycle after the write lands.
            if (tv_hit_q) begin
                trap_vector <= tv_data_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tv_hit) begin
            tv_data_q <= wr.data;
        end
    end

endmodule

/* verilog/csr_stage.sv */
module csr_stage #(
    parameter int          CSR_ADDR_BITS = 12,
    parameter logic [11:0] TVEC_ADDR     = 12'h305
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              branch_flush,
    input  csr_pkg::csr_cmd_e csr_cmd,
    input  logic [31:0]       op1_data,
    input  logic [31:0]       imm_i,
    output logic [31:0]       csr_rdata,
    output logic [31:0]       trap_vector
);

    csr_pkg::csr_req_t req;
    logic [31:0]       rd_data;
    csr_pkg::csr_wr_t  wr;

    // Input side.
    csr_req_decode #(
        .CSR_ADDR_BITS (CSR_ADDR_BITS)
    ) u_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .branch_flush (branch_flush),
        .csr_cmd      (csr_cmd),
        .op1_data     (op1_data),
        .imm_i        (imm_i),
        .req          (req)
    );

    // Register file with read-modify-write.
    csr_file #(
        .CSR_ADDR_BITS (CSR_ADDR_BITS)
    ) u_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .rd_data (rd_data),
        .wr      (wr)
    );

    // Output side.
    csr_result_out #(
        .TVEC_ADDR (TVEC_ADDR)
    ) u_result (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd_data     (rd_data),
        .wr          (wr),
        .csr_rdata   (csr_rdata),
        .trap_vector (trap_vector)
    );

endmodule

/* verif/csr_props.sv */
module csr_props #(
    parameter logic [11:0] TVEC_ADDR = 12'h305
) (
    input logic              clk,
    input logic              arst_n,
    input logic              branch_flush,
    input csr_pkg::csr_cmd_e csr_cmd,
    input csr_pkg::csr_wr_t  wr,
    input logic [31:0]       csr_rdata,
    input logic [31:0]       trap_vector
);

    timeunit 1ns;
    timeprecision 1ps;

    logic cmd_idle;
    logic tv_hit;

    // No request enters the stage this cycle.
    always_comb begin
        cmd_idle = branch_flush || (csr_cmd == csr_pkg::CMD_NONE);
    end

    always_comb begin
        tv_hit = wr.en && (wr.addr == TVEC_ADDR);
    end

    // A request reaches the write port two cycles after it enters the stage.
    wr_needs_cmd: assert property (@(posedge clk) disable iff (!arst_n)
        wr.en |-> $past(!cmd_idle, 2))
        else $error("write port enabled without a command two cycles before");

    cmd_gives_wr: assert property (@(posedge clk) disable iff (!arst_n)
        $past(!cmd_idle, 2) |-> wr.en)
        else $error("command did not reach the write port two cycles later");

    idle_reads_zero: assert property (@(posedge clk) disable iff (!arst_n)
        $past(cmd_idle, 3) |-> (csr_rdata == '0))
        else $error("csr_rdata not zero three cycles after an idle command");

    // The copy moves one cycle after the write lands in storage.
    tvec_moves_on_write: assert property (@(posedge clk) disable iff (!arst_n)
        !$stable(trap_vector) |-> $past(tv_hit, 2))
        else $error("trap_vector changed without a write to the trap vector");

endmodule

/* verif/csr_tb.sv */
module csr_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 16;
    localparam int          ADDR_BITS    = 12;
    localparam logic [11:0] TVEC_ADDR    = 12'h305;
    localparam logic [31:0] DEPTH        = 32'd1 << ADDR_BITS;
    localparam logic [31:0] SEED         = 32'hfc69_6f6e;

    localparam int N_RANDOM = 300;
    localparam int N_ECALL  = 12;
    localparam int N_FLUSH  = 24;
    localparam int N_TVEC   = 40;
    localparam int DRAIN    = 4;
    localparam int N_TESTS  = 5;
    // Upper bound on command cycles over all tests.
    localparam int TOTAL_CMDS = 16 + N_RANDOM + 2 * N_ECALL + 1 + N_FLUSH + 8
                                + N_TVEC + N_TESTS * DRAIN;
    localparam int TIMEOUT_NS = (RESET_CYCLES + TOTAL_CMDS + 200) * CLK_PERIOD;

    typedef struct packed {
        logic        known;
        logic [31:0] value;
    } exp_rd_t;

    logic              clk;
    logic              arst_n;
    logic              branch_flush;
    csr_pkg::csr_cmd_e csr_cmd;
    logic [31:0]       op1_data;
    logic [31:0]       imm_i;
    logic [31:0]       csr_rdata;
    logic [31:0]       trap_vector;

    logic [31:0] model_regs [logic [11:0]];
    logic [31:0] tvec_model;
    exp_rd_t     exp_rd_q [$];
    logic [31:0] exp_tv_q [$];
    logic [31:0] lfsr;
    int          n_checks;
    int          n_errors;
    int          tests_run;
    int          tests_failed;
    int          test_checks0;
    int          test_errors0;

    csr_stage #(
        .CSR_ADDR_BITS (ADDR_BITS),
        .TVEC_ADDR     (TVEC_ADDR)
    ) dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .branch_flush (branch_flush),
        .csr_cmd      (csr_cmd),
        .op1_data     (op1_data),
        .imm_i        (imm_i),
        .csr_rdata    (csr_rdata),
        .trap_vector  (trap_vector)
    );

    bind csr_stage csr_props #(
        .TVEC_ADDR (TVEC_ADDR)
    ) props0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .branch_flush (branch_flush),
        .csr_cmd      (csr_cmd),
        .wr           (wr),
        .csr_rdata    (csr_rdata),
        .trap_vector  (trap_vector)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [11:0] pool_addr(input logic [31:0] sel);
        logic [11:0] addr;
        case (sel[2:0])
            3'd0:    addr = csr_pkg::MCAUSE_ADDR;
            3'd1:    addr = TVEC_ADDR;
            3'd2:    addr = 12'h300;
            3'd3:    addr = 12'h304;
            3'd4:    addr = 12'h340;
            3'd5:    addr = 12'h341;
            3'd6:    addr = 12'h343;
            default: addr = 12'h344;
        endcase
        return addr;
    endfunction

    function automatic logic [11:0] reduce_addr(input logic [31:0] raw);
        return 12'(raw % DEPTH);
    endfunction

    // About one immediate in four carries junk above the index bits.
    function automatic logic [31:0] rand_imm(input logic [11:0] addr);
        logic [31:0] upper;
        upper = '0;
        if (take_bits(2) == 0) begin
            upper = take_bits(20);
        end
        return {upper[19:0], addr};
    endfunction

    function automatic csr_pkg::csr_cmd_e rand_cmd();
        csr_pkg::csr_cmd_e cmd;
        case (take_bits(2))
            1:       cmd = csr_pkg::CMD_SET;
            2:       cmd = csr_pkg::CMD_CLEAR;
            default: cmd = csr_pkg::CMD_WRITE;
        endcase
        return cmd;
    endfunction

    task automatic check_rdata(input logic [31:0] actual, input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED at %0t: csr_rdata is %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic check_tvec(input logic [31:0] actual, input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED at %0t: trap_vector is %h, expected %h", $time, actual, expected);
        end
    endtask

    // One command cycle: check what falls due, drive, then update the model.
    task automatic drive_cmd(
        input csr_pkg::csr_cmd_e cmd,
        input logic [31:0]       operand,
        input logic [31:0]       imm,
        input logic              flush
    );
        exp_rd_t     exp;
        exp_rd_t     due;
        logic [11:0] addr;
        logic [31:0] old;
        logic [31:0] next;
        @(negedge clk);
        if (exp_rd_q.size() == 3) begin
            due = exp_rd_q.pop_front();
            if (due.known) begin
                check_rdata(csr_rdata, due.value);
            end
        end
        if (exp_tv_q.size() == 4) begin
            check_tvec(trap_vector, exp_tv_q.pop_front());
        end
        csr_cmd      = cmd;
        op1_data     = operand;
        imm_i        = imm;
        branch_flush = flush;
        exp = '{known: 1'b1, value: '0};
        if (!flush && (cmd != csr_pkg::CMD_NONE)) begin
            if (cmd == csr_pkg::CMD_ECALL) begin
                addr = reduce_addr({20'd0, csr_pkg::MCAUSE_ADDR});
            end else begin
                addr = reduce_addr(imm);
            end
            exp.known = model_regs.exists(addr);
            old       = exp.known ? model_regs[addr] : '0;
            exp.value = old;
            case (cmd)
                csr_pkg::CMD_WRITE: next = operand;
                csr_pkg::CMD_SET:   next = old | operand;
                csr_pkg::CMD_CLEAR: next = old & ~operand;
                default:            next = csr_pkg::ECALL_CAUSE;
            endcase
            // Set or clear on a register never written leaves it unknown.
            if (exp.known || (cmd == csr_pkg::CMD_WRITE) || (cmd == csr_pkg::CMD_ECALL)) begin
                model_regs[addr] = next;
                if (addr == TVEC_ADDR) begin
                    tvec_model = next;
                end
            end
        end
        exp_rd_q.push_back(exp);
        exp_tv_q.push_back(tvec_model);
    endtask

    task automatic read_reg(input logic [11:0] addr);
        drive_cmd(csr_pkg::CMD_SET, '0, {20'd0, addr}, 1'b0);
    endtask

    task automatic begin_test();
        test_checks0 = n_checks;
        test_errors0 = n_errors;
    endtask

    task automatic end_test(input string name);
        int errs;
        repeat (DRAIN) drive_cmd(csr_pkg::CMD_NONE, '0, '0, 1'b0);
        errs = n_errors - test_errors0;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: %0d checks, ok", name, n_checks - test_checks0);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks, %0d errors", name, n_checks - test_checks0, errs);
        end
    endtask

    task automatic apply_reset();
        exp_rd_t idle;
        idle = '{known: 1'b1, value: '0};
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // Right after reset the pipeline holds only no-ops.
        repeat (3) exp_rd_q.push_back(idle);
        repeat (4) exp_tv_q.push_back('0);
    endtask

    task automatic run_init_test();
        begin_test();
        for (int i = 0; i < 8; i++) begin
            drive_cmd(csr_pkg::CMD_WRITE, take_bits(32), {20'd0, pool_addr(i)}, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            read_reg(pool_addr(i));
        end
        end_test("reset_and_readback");
    endtask

    task automatic run_random_test();
        logic [11:0] addr;
        addr = pool_addr(take_bits(3));
        begin_test();
        for (int i = 0; i < N_RANDOM; i++) begin
            // Keeping the address now and then gives back-to-back hits.
            if (take_bits(2) != 0) begin
                addr = pool_addr(take_bits(3));
            end
            drive_cmd(rand_cmd(), take_bits(32), rand_imm(addr), 1'b0);
        end
        end_test("random_rmw");
    endtask

    task automatic run_ecall_test();
        begin_test();
        for (int i = 0; i < N_ECALL; i++) begin
            if (take_bits(1) == 1) begin
                drive_cmd(csr_pkg::CMD_WRITE, take_bits(32),
                          rand_imm(csr_pkg::MCAUSE_ADDR), 1'b0);
            end
            drive_cmd(csr_pkg::CMD_ECALL, take_bits(32), take_bits(32), 1'b0);
        end
        read_reg(csr_pkg::MCAUSE_ADDR);
        end_test("ecall");
    endtask

    task automatic run_flush_test();
        csr_pkg::csr_cmd_e cmd;
        begin_test();
        for (int i = 0; i < N_FLUSH; i++) begin
            cmd = (take_bits(3) == 0) ? csr_pkg::CMD_ECALL : rand_cmd();
            drive_cmd(cmd, take_bits(32), rand_imm(pool_addr(take_bits(3))), 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            read_reg(pool_addr(i));
        end
        end_test("branch_flush");
    endtask

    task automatic run_tvec_test();
        begin_test();
        for (int i = 0; i < N_TVEC; i++) begin
            case (take_bits(2))
                0: drive_cmd(csr_pkg::CMD_WRITE, take_bits(32), rand_imm(TVEC_ADDR), 1'b0);
                1: drive_cmd(rand_cmd(), take_bits(32), rand_imm(TVEC_ADDR), 1'b0);
                2: drive_cmd(csr_pkg::CMD_WRITE, take_bits(32),
                             rand_imm(pool_addr(take_bits(3))), 1'b0);
                default: drive_cmd(csr_pkg::CMD_NONE, '0, '0, 1'b0);
            endcase
        end
        end_test("trap_vector");
    endtask

    initial begin
        lfsr         = SEED;
        n_checks     = 0;
        n_errors     = 0;
        tests_run    = 0;
        tests_failed = 0;
        tvec_model   = '0;
        arst_n       = 1'b0;
        branch_flush = 1'b0;
        csr_cmd      = csr_pkg::CMD_NONE;
        op1_data     = '0;
        imm_i        = '0;
        apply_reset();
        run_init_test();
        run_random_test();
        run_ecall_test();
        run_flush_test();
        run_tvec_test();
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
verilog/csr_pkg.sv
verilog/csr_req_decode.sv
verilog/csr_file.sv
verilog/csr_result_out.sv
verilog/csr_stage.sv
verif/csr_props.sv
verif/csr_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the CSR stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=csr_tb

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -f files.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# The log decides the result.
if grep -q "^Simulation finished: PASS$" "$LOG_FILE"; then
    echo "run passed"
    exit 0
fi

echo "run failed, see $LOG_FILE"
exit 1
